// ==== acq_engine/acq_engine.sv ====
module acq_engine #(
    parameter int CHANNELS = 4
) (
    input  logic clk,
    input  logic config_done_reset_flag,
    input  logic start,
    input  acq_pkg::acq_op_t op,
    input  acq_pkg::channel_t zcheck_channel,
    output logic busy,
    output logic done,
    output acq_pkg::sample_t [CHANNELS-1:0] samples,
    output acq_pkg::sample_t [acq_pkg::ZCHECK_SAMPLES-1:0] zcheck_samples,
    output acq_pkg::channel_t channel,
    output logic cs,
    output logic sclk,
    output logic mosi,
    input  logic miso
);

    localparam int CYC_W = $clog2(acq_pkg::WORD_CYCLES);
    localparam int CFG_W = $clog2(acq_pkg::CONFIG_WORDS);
    localparam int XFER_CYCLES = 2 * acq_pkg::WORD_BITS;

    acq_pkg::acq_op_t op_q;
    acq_pkg::channel_t zch_q;
    acq_pkg::channel_t word_cnt;
    acq_pkg::channel_t last_word;
    logic [CYC_W-1:0] cyc; // position inside the current word
    acq_pkg::sample_t rx;
    acq_pkg::sample_t tx_bits;
    logic xfer;
    logic word_end;

    always_comb begin
        case (op_q)
            acq_pkg::OP_CONFIG: last_word = acq_pkg::channel_t'(acq_pkg::CONFIG_WORDS - 1);
            acq_pkg::OP_RECORD: last_word = acq_pkg::channel_t'(CHANNELS - 1);
            default: last_word = acq_pkg::channel_t'(acq_pkg::ZCHECK_SAMPLES - 1);
        endcase
    end

    assign xfer = busy && (cyc < CYC_W'(XFER_CYCLES));
    assign word_end = busy && (cyc == CYC_W'(acq_pkg::WORD_CYCLES - 1));
    assign done = word_end && (word_cnt == last_word);

    assign cs = !xfer;
    assign sclk = xfer && cyc[0]; // low on even cycles, high on odd ones

    // a record pass walks the bank, an impedance pass stays on one channel
    assign channel = (op_q == acq_pkg::OP_ZCHECK) ? zch_q : word_cnt;

    assign tx_bits = acq_pkg::CONFIG_REGS[word_cnt[CFG_W-1:0]] << cyc[CYC_W-1:1];
    assign mosi = xfer && (op_q == acq_pkg::OP_CONFIG) && tx_bits[acq_pkg::WORD_BITS-1];

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            busy <= 1'b0;
            op_q <= acq_pkg::OP_CONFIG;
            word_cnt <= '0;
            cyc <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                op_q <= op;
                word_cnt <= '0;
                cyc <= '0;
            end
        end else if (word_end) begin
            cyc <= '0;
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == last_word) busy <= 1'b0;
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) zch_q <= zcheck_channel;

        // miso is taken on the edge that raises sclk, MSB first
        if (xfer && !cyc[0]) rx <= {rx[acq_pkg::WORD_BITS-2:0], miso};

        // cs has just gone high, so rx holds the whole word
        if (busy && cyc == CYC_W'(XFER_CYCLES)) begin
            if (op_q == acq_pkg::OP_RECORD) samples[word_cnt] <= rx;
            else if (op_q == acq_pkg::OP_ZCHECK) zcheck_samples[word_cnt] <= rx;
        end
    end

endmodule

// ==== acq_engine/spi_loopback_model.sv ====
module spi_loopback_model #(
    parameter int SEED = 0
) (
    input  logic clk,
    input  logic config_done_reset_flag,
    input  logic cs,
    input  logic sclk,
    input  acq_pkg::channel_t channel,
    output logic miso
);

    acq_pkg::sample_t word;
    acq_pkg::sample_t shreg;
    logic cs_q;
    logic cs_fall;

    assign word = acq_pkg::sample_t'(SEED) + acq_pkg::sample_t'(channel); // wraps at 2^16
    assign cs_fall = cs_q && !cs;

    // the MSB has to be on the line already in the cycle cs falls
    assign miso = cs_fall ? word[acq_pkg::WORD_BITS-1] : shreg[acq_pkg::WORD_BITS-1];

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) cs_q <= 1'b1;
        else cs_q <= cs;
    end

    always_ff @(posedge clk) begin
        if (cs_fall) shreg <= word;
        else if (!cs && sclk) shreg <= shreg << 1; // step as sclk falls
    end

endmodule

// ==== common/acq_pkg.sv ====
package acq_pkg;

    typedef logic [15:0] sample_t;
    typedef logic [7:0] channel_t;

    typedef enum logic [1:0] {
        OP_CONFIG,
        OP_RECORD,
        OP_ZCHECK
    } acq_op_t;

    localparam int WORD_BITS = 16;
    localparam int CS_GAP = 2; // cs high cycles between two words
    localparam int WORD_CYCLES = 2 * WORD_BITS + CS_GAP;

    localparam int CONFIG_WORDS = 4;
    localparam int ZCHECK_SAMPLES = 8; // repeated conversions per impedance block

    // register writes sent in every configuration pass, word 0 goes out first
    localparam sample_t [CONFIG_WORDS-1:0] CONFIG_REGS = {
        16'h8028,
        16'h8120,
        16'h83de,
        16'h8500
    };

endpackage

// ==== common/seq_pkg.sv ====
package seq_pkg;

    typedef enum logic [3:0] {
        READY,
        CONFIG_START,
        CONFIG_WAIT,
        RECORD_START,
        RECORD_WAIT,
        RECORD_STOP,
        ZCHECK_AMP_START,
        ZCHECK_AMP_WAIT,
        ZCHECK_STIM_START,
        ZCHECK_STIM_WAIT,
        ZCHECK_STOP
    } seq_state_t;

    typedef enum logic {
        BANK_AMP,
        BANK_STIM
    } zcheck_bank_t;

endpackage

// ==== compile.f ====
common/acq_pkg.sv
common/seq_pkg.sv
acq_engine/acq_engine.sv
acq_engine/spi_loopback_model.sv
source/acq_sequencer.sv
source/frame_capture.sv
source/seeg_acq_top.sv
tests/seeg_acq_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module seeg_acq_tb \
    --Mdir obj_dir -o seeg_acq_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/seeg_acq_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit $status

// ==== source/acq_sequencer.sv ====
module acq_sequencer #(
    parameter int AMP_CHANNELS = 4,
    parameter int STIM_CHANNELS = 2
) (
    input  logic clk,
    input  logic config_done_reset_flag,
    input  logic record_start,
    input  logic record_stop,
    input  logic zcheck_start,
    output logic busy,
    output logic zcheck_done,
    output logic amp_start,
    output logic stim_start,
    output acq_pkg::acq_op_t amp_op,
    output acq_pkg::acq_op_t stim_op,
    output acq_pkg::channel_t amp_zcheck_channel,
    output acq_pkg::channel_t stim_zcheck_channel,
    input  logic amp_busy,
    input  logic amp_done,
    input  logic stim_busy,
    input  logic stim_done,
    output logic capture_amp,
    output logic capture_stim,
    output logic publish_record,
    output logic publish_zcheck,
    output seq_pkg::zcheck_bank_t zcheck_bank
);

    seq_pkg::seq_state_t state;
    acq_pkg::acq_op_t op;
    acq_pkg::channel_t amp_ch;
    acq_pkg::channel_t stim_ch;
    logic go_record; // session to run once the opening config pass is done
    logic go_zcheck;
    logic amp_done_flag;
    logic stim_done_flag;
    logic stop_req;
    logic amp_sweep_left;
    logic stim_sweep_left;
    logic frame_done;

    assign busy = (state != seq_pkg::READY);
    assign zcheck_done = (state == seq_pkg::ZCHECK_STOP);

    assign amp_sweep_left = (amp_ch != acq_pkg::channel_t'(AMP_CHANNELS));
    assign stim_sweep_left = (stim_ch != acq_pkg::channel_t'(STIM_CHANNELS));
    assign frame_done = amp_done_flag && stim_done_flag;

    always_comb begin
        case (state)
            seq_pkg::RECORD_START, seq_pkg::RECORD_WAIT, seq_pkg::RECORD_STOP:
                op = acq_pkg::OP_RECORD;
            seq_pkg::ZCHECK_AMP_START, seq_pkg::ZCHECK_AMP_WAIT,
            seq_pkg::ZCHECK_STIM_START, seq_pkg::ZCHECK_STIM_WAIT:
                op = acq_pkg::OP_ZCHECK;
            default:
                op = acq_pkg::OP_CONFIG;
        endcase
    end

    assign amp_op = op;
    assign stim_op = op;
    assign amp_zcheck_channel = amp_ch;
    assign stim_zcheck_channel = stim_ch;

    // start is held until the engine reports busy
    assign amp_start = !amp_busy && ((state == seq_pkg::CONFIG_START) ||
        (state == seq_pkg::RECORD_START && !record_stop) ||
        (state == seq_pkg::ZCHECK_AMP_START && amp_sweep_left));
    assign stim_start = !stim_busy && ((state == seq_pkg::CONFIG_START) ||
        (state == seq_pkg::RECORD_START && !record_stop) ||
        (state == seq_pkg::ZCHECK_STIM_START && stim_sweep_left));

    assign capture_amp = (state == seq_pkg::RECORD_WAIT) && amp_done;
    assign capture_stim = (state == seq_pkg::RECORD_WAIT) && stim_done;
    assign publish_record = (state == seq_pkg::RECORD_WAIT) && frame_done &&
        !stop_req && !record_stop; // a frame cut short by a stop is dropped
    assign publish_zcheck = (state == seq_pkg::ZCHECK_AMP_WAIT && amp_done) ||
        (state == seq_pkg::ZCHECK_STIM_WAIT && stim_done);

    assign zcheck_bank = (state == seq_pkg::ZCHECK_STIM_START ||
        state == seq_pkg::ZCHECK_STIM_WAIT) ? seq_pkg::BANK_STIM : seq_pkg::BANK_AMP;

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            state <= seq_pkg::READY;
            go_record <= 1'b0;
            go_zcheck <= 1'b0;
            amp_done_flag <= 1'b0;
            stim_done_flag <= 1'b0;
            stop_req <= 1'b0;
            amp_ch <= '0;
            stim_ch <= '0;
        end else begin
            // the banks may finish in either order
            if (amp_done) amp_done_flag <= 1'b1;
            if (stim_done) stim_done_flag <= 1'b1;

            case (state)
                seq_pkg::READY: begin
                    amp_ch <= '0;
                    stim_ch <= '0;
                    stop_req <= 1'b0;
                    if (record_start) begin
                        go_record <= 1'b1;
                        state <= seq_pkg::CONFIG_START;
                    end else if (zcheck_start) begin
                        go_zcheck <= 1'b1;
                        state <= seq_pkg::CONFIG_START;
                    end
                end
                seq_pkg::CONFIG_START: begin
                    if (amp_busy && stim_busy) state <= seq_pkg::CONFIG_WAIT;
                end
                seq_pkg::CONFIG_WAIT: begin
                    if (frame_done) begin
                        amp_done_flag <= 1'b0;
                        stim_done_flag <= 1'b0;
                        go_record <= 1'b0;
                        go_zcheck <= 1'b0;
                        if (go_record) state <= seq_pkg::RECORD_START;
                        else if (go_zcheck) state <= seq_pkg::ZCHECK_AMP_START;
                        else state <= seq_pkg::READY; // closing pass finished
                    end
                end
                seq_pkg::RECORD_START: begin
                    if (record_stop) state <= seq_pkg::RECORD_STOP;
                    else if (amp_busy && stim_busy) state <= seq_pkg::RECORD_WAIT;
                end
                seq_pkg::RECORD_WAIT: begin
                    if (record_stop) stop_req <= 1'b1;
                    if (frame_done) begin
                        amp_done_flag <= 1'b0;
                        stim_done_flag <= 1'b0;
                        if (stop_req || record_stop) state <= seq_pkg::RECORD_STOP;
                        else state <= seq_pkg::RECORD_START;
                    end
                end
                seq_pkg::RECORD_STOP: begin
                    // let a running frame drain before the closing pass
                    if (!amp_busy && !stim_busy) begin
                        amp_done_flag <= 1'b0;
                        stim_done_flag <= 1'b0;
                        state <= seq_pkg::CONFIG_START;
                    end
                end
                seq_pkg::ZCHECK_AMP_START: begin
                    if (!amp_sweep_left) state <= seq_pkg::ZCHECK_STIM_START;
                    else if (amp_busy) state <= seq_pkg::ZCHECK_AMP_WAIT;
                end
                seq_pkg::ZCHECK_AMP_WAIT: begin
                    if (amp_done_flag) begin
                        amp_done_flag <= 1'b0;
                        amp_ch <= amp_ch + 1'b1;
                        state <= seq_pkg::ZCHECK_AMP_START;
                    end
                end
                seq_pkg::ZCHECK_STIM_START: begin
                    if (!stim_sweep_left) state <= seq_pkg::ZCHECK_STOP;
                    else if (stim_busy) state <= seq_pkg::ZCHECK_STIM_WAIT;
                end
                seq_pkg::ZCHECK_STIM_WAIT: begin
                    if (stim_done_flag) begin
                        stim_done_flag <= 1'b0;
                        stim_ch <= stim_ch + 1'b1;
                        state <= seq_pkg::ZCHECK_STIM_START;
                    end
                end
                seq_pkg::ZCHECK_STOP: state <= seq_pkg::CONFIG_START;
                default: state <= seq_pkg::READY;
            endcase
        end
    end

endmodule

// ==== source/frame_capture.sv ====
module frame_capture #(
    parameter int AMP_CHANNELS = 4,
    parameter int STIM_CHANNELS = 2
) (
    input  logic clk,
    input  logic config_done_reset_flag,
    input  acq_pkg::sample_t [AMP_CHANNELS-1:0] amp_samples,
    input  acq_pkg::sample_t [STIM_CHANNELS-1:0] stim_samples,
    input  acq_pkg::sample_t [acq_pkg::ZCHECK_SAMPLES-1:0] amp_zcheck,
    input  acq_pkg::sample_t [acq_pkg::ZCHECK_SAMPLES-1:0] stim_zcheck,
    input  logic capture_amp,
    input  logic capture_stim,
    input  logic publish_record,
    input  logic publish_zcheck,
    input  seq_pkg::zcheck_bank_t zcheck_bank,
    output acq_pkg::sample_t [AMP_CHANNELS+STIM_CHANNELS-1:0] data_out_record,
    output acq_pkg::sample_t [acq_pkg::ZCHECK_SAMPLES-1:0] data_out_zcheck,
    output logic data_out_record_valid,
    output logic data_out_zcheck_valid
);

    acq_pkg::sample_t [AMP_CHANNELS-1:0] amp_frame;
    acq_pkg::sample_t [STIM_CHANNELS-1:0] stim_frame;

    always_ff @(posedge clk) begin
        if (capture_amp) amp_frame <= amp_samples;
        if (capture_stim) stim_frame <= stim_samples;
        if (publish_record) data_out_record <= {stim_frame, amp_frame}; // amp channels in the low bits
        if (publish_zcheck) begin
            data_out_zcheck <= (zcheck_bank == seq_pkg::BANK_STIM) ? stim_zcheck : amp_zcheck;
        end
    end

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            data_out_record_valid <= 1'b0;
            data_out_zcheck_valid <= 1'b0;
        end else begin
            data_out_record_valid <= publish_record;
            data_out_zcheck_valid <= publish_zcheck;
        end
    end

endmodule

// ==== source/seeg_acq_top.sv ====
module seeg_acq_top #(
    parameter int AMP_CHANNELS = 4,
    parameter int STIM_CHANNELS = 2,
    parameter int AMP_SEED = 64,
    parameter int STIM_SEED = 2048
) (
    input  logic clk,
    input  logic config_done_reset_flag,
    input  logic record_start,
    input  logic record_stop,
    input  logic zcheck_start,
    input  logic loopback_mode,
    output logic busy,
    output logic zcheck_done,
    output logic amp_cs,
    output logic amp_sclk,
    output logic amp_mosi,
    output logic stim_cs,
    output logic stim_sclk,
    output logic stim_mosi,
    input  logic amp_miso,
    input  logic stim_miso,
    output acq_pkg::sample_t [AMP_CHANNELS+STIM_CHANNELS-1:0] data_out_record,
    output logic data_out_record_valid,
    output acq_pkg::sample_t [acq_pkg::ZCHECK_SAMPLES-1:0] data_out_zcheck,
    output logic data_out_zcheck_valid
);

    logic amp_start, amp_busy, amp_done;
    logic stim_start, stim_busy, stim_done;
    acq_pkg::acq_op_t amp_op, stim_op;
    acq_pkg::channel_t amp_zcheck_channel, stim_zcheck_channel;
    acq_pkg::channel_t amp_channel, stim_channel;
    acq_pkg::sample_t [AMP_CHANNELS-1:0] amp_samples;
    acq_pkg::sample_t [STIM_CHANNELS-1:0] stim_samples;
    acq_pkg::sample_t [acq_pkg::ZCHECK_SAMPLES-1:0] amp_zcheck, stim_zcheck;
    logic capture_amp, capture_stim, publish_record, publish_zcheck;
    seq_pkg::zcheck_bank_t zcheck_bank;
    logic amp_model_miso, stim_model_miso;
    logic amp_miso_sel, stim_miso_sel;

    // external lines are only used with loopback off
    assign amp_miso_sel = loopback_mode ? amp_model_miso : amp_miso;
    assign stim_miso_sel = loopback_mode ? stim_model_miso : stim_miso;

    acq_sequencer #(.AMP_CHANNELS(AMP_CHANNELS), .STIM_CHANNELS(STIM_CHANNELS)) sequencer (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .record_start(record_start), .record_stop(record_stop), .zcheck_start(zcheck_start),
        .busy(busy), .zcheck_done(zcheck_done),
        .amp_start(amp_start), .stim_start(stim_start), .amp_op(amp_op), .stim_op(stim_op),
        .amp_zcheck_channel(amp_zcheck_channel), .stim_zcheck_channel(stim_zcheck_channel),
        .amp_busy(amp_busy), .amp_done(amp_done), .stim_busy(stim_busy), .stim_done(stim_done),
        .capture_amp(capture_amp), .capture_stim(capture_stim),
        .publish_record(publish_record), .publish_zcheck(publish_zcheck),
        .zcheck_bank(zcheck_bank)
    );

    acq_engine #(.CHANNELS(AMP_CHANNELS)) amp_engine (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .start(amp_start), .op(amp_op), .zcheck_channel(amp_zcheck_channel),
        .busy(amp_busy), .done(amp_done), .samples(amp_samples), .zcheck_samples(amp_zcheck),
        .channel(amp_channel), .cs(amp_cs), .sclk(amp_sclk), .mosi(amp_mosi),
        .miso(amp_miso_sel)
    );

    acq_engine #(.CHANNELS(STIM_CHANNELS)) stim_engine (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .start(stim_start), .op(stim_op), .zcheck_channel(stim_zcheck_channel),
        .busy(stim_busy), .done(stim_done), .samples(stim_samples), .zcheck_samples(stim_zcheck),
        .channel(stim_channel), .cs(stim_cs), .sclk(stim_sclk), .mosi(stim_mosi),
        .miso(stim_miso_sel)
    );

    spi_loopback_model #(.SEED(AMP_SEED)) amp_model (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .cs(amp_cs), .sclk(amp_sclk), .channel(amp_channel), .miso(amp_model_miso)
    );

    spi_loopback_model #(.SEED(STIM_SEED)) stim_model (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .cs(stim_cs), .sclk(stim_sclk), .channel(stim_channel), .miso(stim_model_miso)
    );

    frame_capture #(.AMP_CHANNELS(AMP_CHANNELS), .STIM_CHANNELS(STIM_CHANNELS)) capture (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .amp_samples(amp_samples), .stim_samples(stim_samples),
        .amp_zcheck(amp_zcheck), .stim_zcheck(stim_zcheck),
        .capture_amp(capture_amp), .capture_stim(capture_stim),
        .publish_record(publish_record), .publish_zcheck(publish_zcheck),
        .zcheck_bank(zcheck_bank),
        .data_out_record(data_out_record), .data_out_zcheck(data_out_zcheck),
        .data_out_record_valid(data_out_record_valid),
        .data_out_zcheck_valid(data_out_zcheck_valid)
    );

endmodule

// ==== tests/seeg_acq_tb.sv ====
module seeg_acq_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AMP_CHANNELS = 4;
    localparam int STIM_CHANNELS = 2;
    localparam int AMP_SEED = 64;
    localparam int STIM_SEED = 2048;
    localparam int RECORD_BITS = (AMP_CHANNELS + STIM_CHANNELS) * 16;
    localparam int ZCHECK_BITS = acq_pkg::ZCHECK_SAMPLES * 16;
    localparam int WIDE = 128;
    localparam int TIMEOUT = 5000; // cycles allowed for any single wait

    logic clk, config_done_reset_flag;
    logic record_start, record_stop, zcheck_start, loopback_mode;
    logic busy, zcheck_done;
    logic amp_cs, amp_sclk, amp_mosi, stim_cs, stim_sclk, stim_mosi;
    logic amp_miso, stim_miso;
    logic [RECORD_BITS-1:0] data_out_record;
    logic [ZCHECK_BITS-1:0] data_out_zcheck;
    logic data_out_record_valid, data_out_zcheck_valid;

    string test_name;
    int rec_count;
    int zc_count;
    int zdone_count;
    int frames;
    int amp_low_cycles;
    int stim_low_cycles;
    int amp_words;
    int stim_words;

    seeg_acq_top #(
        .AMP_CHANNELS(AMP_CHANNELS), .STIM_CHANNELS(STIM_CHANNELS),
        .AMP_SEED(AMP_SEED), .STIM_SEED(STIM_SEED)
    ) dut0 (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .record_start(record_start), .record_stop(record_stop), .zcheck_start(zcheck_start),
        .loopback_mode(loopback_mode), .busy(busy), .zcheck_done(zcheck_done),
        .amp_cs(amp_cs), .amp_sclk(amp_sclk), .amp_mosi(amp_mosi),
        .stim_cs(stim_cs), .stim_sclk(stim_sclk), .stim_mosi(stim_mosi),
        .amp_miso(amp_miso), .stim_miso(stim_miso),
        .data_out_record(data_out_record), .data_out_record_valid(data_out_record_valid),
        .data_out_zcheck(data_out_zcheck), .data_out_zcheck_valid(data_out_zcheck_valid)
    );

    always #20 clk = ~clk;

    // a chip answers a conversion with its seed plus the channel, wrapping at 16 bits
    function automatic logic [15:0] expected_sample(input int seed, input int channel);
        return 16'(seed + channel);
    endfunction

    function automatic logic [RECORD_BITS-1:0] expected_frame(input logic loopback);
        logic [RECORD_BITS-1:0] frame;
        frame = '0;
        for (int k = 0; k < AMP_CHANNELS; k++) begin
            frame[16*k +: 16] = loopback ? expected_sample(AMP_SEED, k) : 16'hffff;
        end
        for (int k = 0; k < STIM_CHANNELS; k++) begin // stim channels sit above the amp ones
            frame[16*(AMP_CHANNELS+k) +: 16] = loopback ? expected_sample(STIM_SEED, k) : 16'h0;
        end
        return frame;
    endfunction

    function automatic logic [ZCHECK_BITS-1:0] expected_block(input int index);
        logic [ZCHECK_BITS-1:0] block;
        logic [15:0] s;
        if (index < AMP_CHANNELS) s = expected_sample(AMP_SEED, index);
        else s = expected_sample(STIM_SEED, index - AMP_CHANNELS);
        for (int j = 0; j < acq_pkg::ZCHECK_SAMPLES; j++) begin
            block[16*j +: 16] = s;
        end
        return block;
    endfunction

    task automatic compare_value(input string name, input logic [WIDE-1:0] expected,
                                 input logic [WIDE-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Test failures found");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    // a word holds cs low for 2 * WORD_BITS cycles while sclk toggles, starting low
    task automatic check_serial_lines(input string bank, input logic cs, input logic sclk,
                                      input logic mosi, inout int low_cycles, inout int words);
        if (cs) begin
            if (low_cycles != 0) begin
                compare_value({bank, " cs low cycles"}, WIDE'(2 * acq_pkg::WORD_BITS),
                    WIDE'(low_cycles));
                words++;
            end
            low_cycles = 0;
            compare_value({bank, " sclk while cs high"}, WIDE'(0), WIDE'(sclk));
            compare_value({bank, " mosi while cs high"}, WIDE'(0), WIDE'(mosi));
        end else begin
            compare_value({bank, " sclk phase"}, WIDE'(low_cycles % 2), WIDE'(sclk));
            low_cycles++;
        end
    endtask

    // inputs change and outputs are read 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_busy_level(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (busy !== level) timeout_fail(what);
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (rec_count < target && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (rec_count < target) timeout_fail("record frames");
    endtask

    task automatic wait_zcheck_done();
        int n;
        n = 0;
        while (zcheck_done !== 1'b1 && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (zcheck_done !== 1'b1) timeout_fail("zcheck_done");
    endtask

    task automatic launch_session(input logic use_record);
        if (use_record) record_start = 1'b1;
        else zcheck_start = 1'b1;
        next_cycle();
        record_start = 1'b0;
        zcheck_start = 1'b0;
        compare_value({test_name, " busy after start"}, WIDE'(1), WIDE'(busy));
    endtask

    task automatic stop_record();
        record_stop = 1'b1;
        next_cycle();
        record_stop = 1'b0;
    endtask

    // compares every published result against the reference as it appears
    always @(negedge clk) begin
        if (!config_done_reset_flag) begin
            if (data_out_record_valid) begin
                compare_value({test_name, " frame"}, WIDE'(expected_frame(loopback_mode)),
                    WIDE'(data_out_record));
                rec_count++;
            end
            if (data_out_zcheck_valid) begin
                if (zc_count >= AMP_CHANNELS + STIM_CHANNELS) begin
                    $display("Test failures found");
                    $fatal(1, "an impedance block appeared after the last channel");
                end else begin
                    compare_value($sformatf("%s block %0d", test_name, zc_count),
                        WIDE'(expected_block(zc_count)), WIDE'(data_out_zcheck));
                    zc_count++;
                end
            end
            if (zcheck_done) zdone_count++;
            check_serial_lines("amp", amp_cs, amp_sclk, amp_mosi, amp_low_cycles, amp_words);
            check_serial_lines("stim", stim_cs, stim_sclk, stim_mosi, stim_low_cycles,
                stim_words);
        end
    end

    initial begin
        void'($urandom(54761));
        clk = 1'b0;
        config_done_reset_flag = 1'b1;
        record_start = 1'b0;
        record_stop = 1'b0;
        zcheck_start = 1'b0;
        loopback_mode = 1'b1;
        amp_miso = 1'b0;
        stim_miso = 1'b0;
        rec_count = 0;
        zc_count = 0;
        zdone_count = 0;
        amp_low_cycles = 0;
        stim_low_cycles = 0;
        amp_words = 0;
        stim_words = 0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        #5;
        config_done_reset_flag = 1'b0;
        compare_value("reset busy", WIDE'(0), WIDE'(busy));
        compare_value("reset zcheck_done", WIDE'(0), WIDE'(zcheck_done));
        compare_value("reset record valid", WIDE'(0), WIDE'(data_out_record_valid));
        compare_value("reset zcheck valid", WIDE'(0), WIDE'(data_out_zcheck_valid));

        test_name = "record loopback";
        frames = 2 + int'($urandom % 3);
        launch_session(1'b1);
        wait_frames(frames);
        stop_record();
        wait_busy_level(1'b0, "busy to fall after record_stop");
        compare_value("record frames after stop", WIDE'(frames), WIDE'(rec_count));

        // the sweep also shows that a command is taken after a stopped session
        test_name = "impedance sweep";
        amp_words = 0;
        stim_words = 0;
        launch_session(1'b0);
        wait_zcheck_done();
        compare_value("blocks at zcheck_done", WIDE'(AMP_CHANNELS + STIM_CHANNELS),
            WIDE'(zc_count));
        wait_busy_level(1'b0, "busy to fall after the impedance sweep");
        compare_value("zcheck_done pulses", WIDE'(1), WIDE'(zdone_count));
        // two config passes around one impedance pass per channel
        compare_value("amp words in the sweep",
            WIDE'(2 * acq_pkg::CONFIG_WORDS + AMP_CHANNELS * acq_pkg::ZCHECK_SAMPLES),
            WIDE'(amp_words));
        compare_value("stim words in the sweep",
            WIDE'(2 * acq_pkg::CONFIG_WORDS + STIM_CHANNELS * acq_pkg::ZCHECK_SAMPLES),
            WIDE'(stim_words));

        test_name = "external miso";
        loopback_mode = 1'b0;
        amp_miso = 1'b1;
        stim_miso = 1'b0;
        rec_count = 0;
        zc_count = 0;
        zdone_count = 0;
        launch_session(1'b1);
        zcheck_start = 1'b1; // has to be ignored while busy
        next_cycle();
        zcheck_start = 1'b0;
        wait_frames(2);
        stop_record();
        wait_busy_level(1'b0, "busy to fall after the external record session");
        compare_value("external frames", WIDE'(2), WIDE'(rec_count));
        compare_value("zcheck blocks while busy", WIDE'(0), WIDE'(zc_count));
        compare_value("zcheck_done while busy", WIDE'(0), WIDE'(zdone_count));

        $display("All tests passed!");
        $finish;
    end

endmodule
